// File: all.f
+incdir+.
rs_pkg.sv
rs_queue_ctrl.sv
rs_entry_array.sv
rs_issue_select.sv
rs_mul_station.sv
tb_clock_gen.sv
rs_mul_tb.sv

// File: rs_consts.svh
`ifndef RS_CONSTS_SVH
`define RS_CONSTS_SVH

// Station geometry
`define RS_DEPTH 16
`define RS_WINDOW 8
`define RS_WAKE_PORTS 4

// Slot index must cover RS_DEPTH exactly so pointers wrap for free
`define RS_IDX_W 4

// Field widths
`define RS_TAG_W 8
`define RS_PC_W 32

`endif

// File: rs_entry_array.sv
`timescale 1ns/10ps
`include "rs_consts.svh"

module rs_entry_array import rs_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispatch_valid,
    input  logic                 dispatch_ready,
    input  rs_dispatch_t         dispatch,
    input  rs_idx_t              tail,
    input  wake_bus_t            wake,
    input  logic                 issue_fire,
    input  rs_idx_t              issue_idx,
    output logic [`RS_DEPTH-1:0] busy,
    output logic [`RS_DEPTH-1:0] ready,
    output rs_issue_t            entries [0:`RS_DEPTH-1]
);

    logic [`RS_DEPTH-1:0] src1_rdy;
    logic [`RS_DEPTH-1:0] src2_rdy;
    logic accept;

    // True when any valid port broadcasts this tag
    function automatic logic tag_woken(input tag_t tag, input wake_bus_t bus);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < `RS_WAKE_PORTS; p++) begin
            if (bus[p].valid && (bus[p].tag == tag)) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    assign accept = dispatch_valid && dispatch_ready;
    assign ready  = src1_rdy & src2_rdy;

    // Busy and operand ready state
    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= '0;
            src1_rdy <= '0;
            src2_rdy <= '0;
        end else begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (busy[i] && tag_woken(entries[i].src1, wake)) begin
                    src1_rdy[i] <= 1'b1;
                end
                if (busy[i] && tag_woken(entries[i].src2, wake)) begin
                    src2_rdy[i] <= 1'b1;
                end
            end
            if (issue_fire) begin
                busy[issue_idx] <= 1'b0; // Slot handed to issue register
            end
            if (accept) begin
                busy[tail] <= 1'b1;
                // Same-cycle broadcast counts as ready at dispatch
                src1_rdy[tail] <= dispatch.src1_ready || tag_woken(dispatch.src1, wake);
                src2_rdy[tail] <= dispatch.src2_ready || tag_woken(dispatch.src2, wake);
            end
        end
    end

    // Payload storage
    always_ff @(posedge clk) begin
        if (accept) begin
            entries[tail] <= '{
                pc:   dispatch.pc,
                rd:   dispatch.rd,
                src1: dispatch.src1,
                src2: dispatch.src2
            };
        end
    end

    // Tail from the queue control must never land on a live entry
    a_no_overwrite: assert property (
        @(posedge clk) disable iff (reset)
        accept |-> !busy[tail]
    ) else $error("rs_entry_array: dispatch into busy slot %0d", tail);

    // Issue select only picks live, fully woken entries
    a_issue_live: assert property (
        @(posedge clk) disable iff (reset)
        issue_fire |-> (busy[issue_idx] && ready[issue_idx])
    ) else $error("rs_entry_array: issue of idle slot %0d", issue_idx);

endmodule

// File: rs_issue_select.sv
`timescale 1ns/10ps
`include "rs_consts.svh"

module rs_issue_select import rs_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  rs_idx_t              head,
    input  logic [`RS_DEPTH-1:0] busy,
    input  logic [`RS_DEPTH-1:0] ready,
    input  rs_issue_t            entries [0:`RS_DEPTH-1],
    input  logic                 issue_ready,
    output logic                 issue_valid,
    output rs_issue_t            issue,
    output logic                 issue_fire,
    output rs_idx_t              issue_idx
);

    logic    found;
    rs_idx_t pick;
    rs_idx_t slot;
    logic    reg_free;

    // Oldest ready entry within the window, head first
    always_comb begin
        found = 1'b0;
        pick  = head;
        slot  = head;
        for (int k = 0; k < `RS_WINDOW; k++) begin
            slot = head + rs_idx_t'(k); // Wraps at RS_DEPTH
            if (!found && busy[slot] && ready[slot]) begin
                found = 1'b1;
                pick  = slot;
            end
        end
    end

    // Output register empty or emptied this cycle
    assign reg_free = !issue_valid || issue_ready;

    assign issue_fire = found && reg_free;
    assign issue_idx  = pick;

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else if (issue_fire) begin
            issue_valid <= 1'b1;
        end else if (issue_ready) begin
            issue_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            issue <= entries[pick];
        end
    end

    // Payload held under back-pressure
    a_issue_stable: assert property (
        @(posedge clk) disable iff (reset)
        (issue_valid && !issue_ready) |=> (issue_valid && $stable(issue))
    ) else $error("rs_issue_select: issue payload changed while stalled");

endmodule

// File: rs_mul_station.sv
`timescale 1ns/10ps
`include "rs_consts.svh"

module rs_mul_station import rs_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    // Dispatch from rename
    input  logic         dispatch_valid,
    output logic         dispatch_ready,
    input  rs_dispatch_t dispatch,
    // Result broadcasts
    input  wake_bus_t    wake,
    // To the multiplier
    output logic         issue_valid,
    input  logic         issue_ready,
    output rs_issue_t    issue
);

    rs_idx_t              head;
    rs_idx_t              tail;
    logic [`RS_DEPTH-1:0] busy;
    logic [`RS_DEPTH-1:0] ready;
    rs_issue_t            entries [0:`RS_DEPTH-1];
    logic                 issue_fire;
    rs_idx_t              issue_idx;

    rs_queue_ctrl u_queue_ctrl (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .busy           (busy),
        .dispatch_ready (dispatch_ready),
        .head           (head),
        .tail           (tail)
    );

    rs_entry_array u_entry_array (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch       (dispatch),
        .tail           (tail),
        .wake           (wake),
        .issue_fire     (issue_fire),
        .issue_idx      (issue_idx),
        .busy           (busy),
        .ready          (ready),
        .entries        (entries)
    );

    rs_issue_select u_issue_select (
        .clk            (clk),
        .reset          (reset),
        .head           (head),
        .busy           (busy),
        .ready          (ready),
        .entries        (entries),
        .issue_ready    (issue_ready),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .issue_fire     (issue_fire),
        .issue_idx      (issue_idx)
    );

endmodule

// File: rs_mul_tb.sv
`timescale 1ns/10ps
`include "rs_consts.svh"

module rs_mul_tb import rs_pkg::*; ();

    localparam int TOTAL_OPS = 40 + 8 + 3 + 6 + 18; // Dispatches over all tests

    typedef struct packed {
        rs_issue_t op;
        logic      r1;
        logic      r2;
    } model_op_t;

    logic         clk;
    logic         reset;
    logic         dispatch_valid;
    logic         dispatch_ready;
    rs_dispatch_t dispatch;
    wake_bus_t    wake;
    logic         issue_valid;
    logic         issue_ready;
    rs_issue_t    issue;

    integer      seed = 69;
    model_op_t   pend [$]; // Accepted and not yet issued, oldest first
    tag_t        next_tag = 8'd1;
    tag_t        next_rd = 8'd0;
    logic        in_order = 1'b1;
    string       test_name = "reset";
    logic        hold_valid = 1'b0;
    rs_issue_t   hold_issue;

    tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(2)) u_clock_gen (.clk(clk), .reset(reset));

    rs_mul_station u_dut (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch       (dispatch),
        .wake           (wake),
        .issue_valid    (issue_valid),
        .issue_ready    (issue_ready),
        .issue          (issue)
    );

    task automatic check_issue(input string name, input rs_issue_t exp, input rs_issue_t act);
        if (exp !== act) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "issue payload mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    function automatic int find_op(input tag_t rd);
        int idx;
        idx = -1;
        for (int k = 0; k < pend.size(); k++) begin
            if (pend[k].op.rd == rd) begin
                idx = k;
            end
        end
        return idx;
    endfunction

    function automatic tag_t alloc_tag();
        tag_t t;
        t = next_tag;
        next_tag = next_tag + 1'b1;
        return t;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Called on a falling edge, returns on the next one
    task automatic broadcast(input tag_t t);
        int p;
        p = $unsigned($random(seed)) % `RS_WAKE_PORTS;
        wake[p].valid = 1'b1;
        wake[p].tag = t;
        @(negedge clk);
        wake = '0;
    endtask

    task automatic send_op(input tag_t s1, input tag_t s2, input logic r1, input logic r2,
                           input logic byp, input tag_t byp_tag);
        int p;
        p = $unsigned($random(seed)) % `RS_WAKE_PORTS;
        dispatch = '{pc: pc_t'($random(seed)), rd: next_rd, src1: s1, src2: s2,
                     src1_ready: r1, src2_ready: r2};
        next_rd = next_rd + 1'b1;
        dispatch_valid = 1'b1;
        if (byp) begin
            wake[p].valid = 1'b1; // Same cycle as the dispatch
            wake[p].tag = byp_tag;
        end
        @(posedge clk);
        while (!dispatch_ready) begin
            @(negedge clk);
            wake = '0;
            @(posedge clk);
        end
        @(negedge clk);
        dispatch_valid = 1'b0;
        wake = '0;
    endtask

    task automatic send_ready_op();
        send_op(tag_t'($random(seed)), tag_t'($random(seed)), 1'b1, 1'b1, 1'b0, '0);
    endtask

    task automatic wait_drain();
        while (pend.size() != 0) @(negedge clk);
    endtask

    // Reference model and output checks
    always @(posedge clk) begin : monitor
        int idx;
        model_op_t m;
        if (!reset) begin
            if (hold_valid) begin
                check_flag({test_name, " issue_valid held"}, 1'b1, issue_valid);
                check_issue({test_name, " issue held"}, hold_issue, issue);
            end
            hold_valid = issue_valid && !issue_ready;
            hold_issue = issue;
            if (issue_valid && issue_ready) begin
                idx = in_order ? 0 : find_op(issue.rd);
                if (pend.size() == 0 || idx < 0) begin
                    $display("Issued an operation that was never dispatched, rd %h", issue.rd);
                    $display("TEST FAILED");
                    $fatal(1, "unknown issue");
                end else begin
                    check_issue(test_name, pend[idx].op, issue);
                    check_flag({test_name, " sources woken"}, 1'b1, pend[idx].r1 && pend[idx].r2);
                    pend.delete(idx);
                end
            end
            if (dispatch_valid && dispatch_ready) begin
                m.op.pc = dispatch.pc;
                m.op.rd = dispatch.rd;
                m.op.src1 = dispatch.src1;
                m.op.src2 = dispatch.src2;
                m.r1 = dispatch.src1_ready;
                m.r2 = dispatch.src2_ready;
                pend.push_back(m);
            end
            // Wakes after the push so a same-cycle broadcast counts
            for (int p = 0; p < `RS_WAKE_PORTS; p++) begin
                for (int k = 0; k < pend.size(); k++) begin
                    m = pend[k];
                    if (wake[p].valid && m.op.src1 == wake[p].tag) m.r1 = 1'b1;
                    if (wake[p].valid && m.op.src2 == wake[p].tag) m.r2 = 1'b1;
                    pend[k] = m;
                end
            end
        end
    end

    initial begin
        repeat (TOTAL_OPS * (`RS_DEPTH + 20)) @(posedge clk);
        $display("Watchdog expired before all tests finished");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        tag_t tags [$];
        tag_t t;
        tag_t blocked_rd;
        int j;
        dispatch_valid = 1'b0;
        dispatch = '0;
        wake = '0;
        issue_ready = 1'b1;
        @(negedge clk);
        while (reset) @(negedge clk);
        check_flag("reset issue_valid", 1'b0, issue_valid);
        check_flag("reset dispatch_ready", 1'b1, dispatch_ready);

        test_name = "in_order";
        for (int i = 0; i < 40; i++) begin
            send_ready_op();
            idle($unsigned($random(seed)) % 3);
        end
        wait_drain();

        test_name = "wakeup";
        in_order = 1'b0;
        for (int i = 0; i < 8; i++) begin
            tags.push_back(alloc_tag());
            tags.push_back(alloc_tag());
            send_op(tags[2*i], tags[2*i+1], 1'b0, 1'b0, 1'b0, '0);
        end
        for (int i = tags.size() - 1; i > 0; i--) begin
            j = $unsigned($random(seed)) % (i + 1); // Shuffle broadcast order
            t = tags[i];
            tags[i] = tags[j];
            tags[j] = t;
        end
        foreach (tags[i]) begin
            broadcast(tags[i]);
            idle($unsigned($random(seed)) % 2);
        end
        wait_drain();

        test_name = "bypass";
        for (int i = 0; i < 3; i++) begin
            t = alloc_tag();
            send_op(t, tag_t'($random(seed)), 1'b0, 1'b1, 1'b1, t);
        end
        wait_drain();
        idle(`RS_DEPTH); // Let the head catch up

        test_name = "out_of_order";
        t = alloc_tag();
        blocked_rd = next_rd;
        send_op(t, tag_t'($random(seed)), 1'b0, 1'b1, 1'b0, '0);
        for (int i = 0; i < 5; i++) send_ready_op();
        // Ready ops behind the blocked one get a bounded time to pass it
        for (int i = 0; i < 4 * `RS_WINDOW && pend.size() > 1; i++) begin
            @(negedge clk);
        end
        check_flag("out_of_order ready ops passed blocked op", 1'b1,
                   pend.size() == 1 && pend[0].op.rd == blocked_rd);
        broadcast(t);
        wait_drain();
        idle(`RS_DEPTH);

        test_name = "full_queue";
        in_order = 1'b1;
        issue_ready = 1'b0;
        send_ready_op();
        while (!issue_valid) @(negedge clk);
        for (int i = 0; i < `RS_DEPTH; i++) begin
            check_flag("full_queue dispatch_ready before full", 1'b1, dispatch_ready);
            send_ready_op();
        end
        check_flag("full_queue dispatch_ready when full", 1'b0, dispatch_ready);
        dispatch = '{pc: pc_t'($random(seed)), rd: next_rd, src1: '0, src2: '0,
                     src1_ready: 1'b1, src2_ready: 1'b1};
        next_rd = next_rd + 1'b1;
        dispatch_valid = 1'b1; // Offer held until a slot frees
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            check_flag("full_queue dispatch_ready held low", 1'b0, dispatch_ready);
        end
        issue_ready = 1'b1;
        while (!dispatch_ready) @(negedge clk);
        @(negedge clk);
        dispatch_valid = 1'b0;
        wait_drain();
        idle(4);

        if (pend.size() == 0 && !issue_valid) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("Operations still in flight at the end of the run");
            $display("TEST FAILED");
            $fatal(1, "residual operations");
        end
    end

endmodule

// File: rs_pkg.sv
`include "rs_consts.svh"

package rs_pkg;

    typedef logic [`RS_TAG_W-1:0] tag_t; // Physical register tag
    typedef logic [`RS_PC_W-1:0] pc_t;
    typedef logic [`RS_IDX_W-1:0] rs_idx_t; // Slot index
    typedef logic [`RS_IDX_W:0] rs_count_t; // 0 .. RS_DEPTH

    // Dispatch payload from rename
    typedef struct packed {
        pc_t  pc;
        tag_t rd;
        tag_t src1;
        tag_t src2;
        logic src1_ready;
        logic src2_ready;
    } rs_dispatch_t;

    // Entry as stored and as sent to the multiplier
    typedef struct packed {
        pc_t  pc;
        tag_t rd;
        tag_t src1;
        tag_t src2;
    } rs_issue_t;

    // One result broadcast port
    typedef struct packed {
        logic valid;
        tag_t tag;
    } wake_t;

    typedef wake_t [`RS_WAKE_PORTS-1:0] wake_bus_t;

endpackage

// File: rs_queue_ctrl.sv
`timescale 1ns/10ps
`include "rs_consts.svh"

module rs_queue_ctrl import rs_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 dispatch_valid,
    input  logic [`RS_DEPTH-1:0] busy,
    output logic                 dispatch_ready,
    output rs_idx_t              head,
    output rs_idx_t              tail
);

    rs_count_t count; // Slots between head and tail
    logic accept;
    logic reclaim;

    assign dispatch_ready = (count != rs_count_t'(`RS_DEPTH));
    assign accept = dispatch_valid && dispatch_ready;

    // Head slot already issued, so it can be given back
    assign reclaim = (count != '0) && !busy[head];

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (accept) begin
                tail <= tail + 1'b1; // Wraps at RS_DEPTH
            end
            if (reclaim) begin
                head <= head + 1'b1;
            end
            case ({accept, reclaim})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count; // Both or neither
                end
            endcase
        end
    end

    // Occupancy bound
    a_count_bound: assert property (
        @(posedge clk) disable iff (reset)
        count <= rs_count_t'(`RS_DEPTH)
    ) else $error("rs_queue_ctrl: occupancy %0d above depth", count);

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0; // Released between edges
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule
